//--- tests/card_game_vectors.txt
# key whose f1_color f1_number f2_color f2_number draw_count match game_over, all hex
# color 0 none 1 red 2 green 3 blue; whose 0 player 1, 1 player 2
0 0 0 0 0 0 00 0 0
1 0 0 0 0 0 00 0 0   # out of turn
0 0 0 0 0 0 00 0 0
3 0 0 0 0 0 00 0 0   # held for three cycles
3 1 0 0 0 0 00 0 0
3 1 0 0 0 0 00 0 0
0 1 1 5 0 0 01 0 0
0 1 1 5 0 0 01 0 0
1 1 1 5 0 0 01 0 0
0 0 1 5 0 0 01 0 0
0 0 1 5 0 0 01 0 0
0 0 1 5 3 2 02 0 0
3 0 1 5 3 2 02 0 0   # back to back turns
1 1 1 5 3 2 02 0 0
0 0 1 5 3 2 02 0 0
0 0 1 3 3 2 03 0 0
0 0 1 3 2 3 04 1 0   # numbers equal
0 0 1 3 2 3 04 1 0
3 0 1 3 2 3 04 1 0
0 1 1 3 2 3 04 1 0
0 1 1 3 2 3 04 1 0
0 1 3 2 2 3 05 0 0   # match broken
0 1 3 2 2 3 05 0 0
0 1 3 2 2 3 05 0 0
1 1 3 2 2 3 05 0 0
0 0 3 2 2 3 05 0 0
0 0 3 2 2 3 05 0 0
0 0 3 2 2 2 06 1 1   # sixth draw ends the game
3 0 3 2 2 2 06 1 1
3 0 3 2 2 2 06 1 1
3 0 3 2 2 2 06 1 1
0 0 3 2 2 2 06 1 1
1 0 3 2 2 2 06 1 1
0 0 3 2 2 2 06 1 1
3 0 3 2 2 2 06 1 1
0 0 3 2 2 2 06 1 1
1 0 3 2 2 2 06 1 1
0 0 3 2 2 2 06 1 1

//--- compile.f
design/card_game_pkg.sv
design/card_if.sv
design/turn_ctrl.sv
design/lfsr_draw.sv
design/card_decode.sv
design/table_state.sv
design/card_game_top.sv
tests/card_game_asserts.sv
tests/card_game_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the card game testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f compile.f --top-module card_game_tb \
    -Mdir "$build_dir" -o card_game_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

"./$build_dir/card_game_sim" +verilator+error+limit+10 > "$log_file" 2>&1
status=$?
cat "$log_file"

if grep -q "Checks failed" "$log_file"; then
    echo "FAIL"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "FAIL: simulator exited with status $status"
    exit 1
fi

echo "PASS"
exit 0

//--- tests/card_game_tb.sv
module card_game_tb
    import card_game_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned max_draws   = 6;
    localparam int unsigned num_cols    = 9;
    localparam string       vector_file = "tests/card_game_vectors.txt";

    logic             clk;
    logic             rst;
    logic [3:0]       keypad_in;
    player_e          whose;
    color_e           face1_color;
    color_e           face2_color;
    logic [num_w-1:0] face1_number;
    logic [num_w-1:0] face2_number;
    logic [cnt_w-1:0] draw_count;
    logic             match;
    logic             game_over;

    logic [7:0]  vectors [$]; // rows of num_cols fields, flattened.
    int unsigned num_vectors = 0;
    int unsigned cycle_limit = 0;
    int unsigned cycle_count = 0;

    card_game_top #(
        .max_draws (max_draws)
    ) i_dut (
        .clk          (clk),
        .rst          (rst),
        .keypad_in    (keypad_in),
        .whose        (whose),
        .face1_color  (face1_color),
        .face2_color  (face2_color),
        .face1_number (face1_number),
        .face2_number (face2_number),
        .draw_count   (draw_count),
        .match        (match),
        .game_over    (game_over)
    );

    always #50 clk = ~clk; // 100 ns period.

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            report_failure($sformatf("timeout: the run did not end within %0d clock cycles",
                                     cycle_limit));
        end
    end

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("Error: at %0d ns, %s expected %0h, actual %0h",
                                     $time, name, expected, actual));
        end
    endtask

    task automatic load_vectors();
        int         fd;
        int         fields;
        int         c;
        string      line;
        logic [7:0] col [num_cols];
        fd = $fopen(vector_file, "r");
        if (fd == 0) begin
            report_failure($sformatf("could not open the vector file %s", vector_file));
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin // skip blank and comment lines.
                fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                                 col[0], col[1], col[2], col[3], col[4],
                                 col[5], col[6], col[7], col[8]);
                if (fields != num_cols) begin
                    report_failure($sformatf("malformed line in the vector file: %s", line));
                end
                for (c = 0; c < num_cols; c++) begin
                    vectors.push_back(col[c]);
                end
            end
        end
        $fclose(fd);
        num_vectors = vectors.size() / num_cols;
        if (num_vectors == 0) begin
            report_failure("the vector file holds no vectors");
        end
        cycle_limit = num_vectors + 10;
    endtask

    task automatic apply_reset();
        repeat (2) @(posedge clk);
        rst <= 1'b1;
    endtask

    initial begin
        int unsigned idx;
        int unsigned base;
        clk       = 1'b0;
        rst       = 1'b0;
        keypad_in = 4'd0;
        load_vectors();
        apply_reset();
        for (idx = 0; idx < num_vectors; idx++) begin
            base = idx * num_cols;
            @(posedge clk);
            keypad_in <= vectors[base][3:0];
            @(negedge clk); // outputs are settled mid-cycle.
            if (i_dut.i_asserts.any_fail) begin
                report_failure("an assertion on the DUT failed");
            end
            check_value("whose", vectors[base+1], 8'(whose));
            check_value("face1_color", vectors[base+2], 8'(face1_color));
            check_value("face1_number", vectors[base+3], 8'(face1_number));
            check_value("face2_color", vectors[base+4], 8'(face2_color));
            check_value("face2_number", vectors[base+5], 8'(face2_number));
            check_value("draw_count", vectors[base+6], draw_count);
            check_value("match", vectors[base+7], 8'(match));
            check_value("game_over", vectors[base+8], 8'(game_over));
        end
        if (!i_dut.i_asserts.any_fail) begin
            $display("All checks passed");
            $finish;
        end else begin
            report_failure("an assertion on the DUT failed");
        end
    end

endmodule

//--- tests/card_game_asserts.sv
module card_game_asserts
    import card_game_pkg::*;
#(
    parameter int unsigned max_draws = 20
) (
    input logic             clk,
    input logic             rst,
    input logic             draw,
    input player_e          draw_owner,
    input player_e          whose,
    input logic [cnt_w-1:0] draw_count,
    input logic             game_over
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [cnt_w-1:0] max_cnt = cnt_w'(max_draws);

    logic draw_fail  = 1'b0;
    logic turn_fail  = 1'b0;
    logic count_fail = 1'b0;
    logic over_fail  = 1'b0;
    logic any_fail;

    assign any_fail = draw_fail | turn_fail | count_fail | over_fail; // seen by the testbench.

    // two draws in a row are only legal when the turn passed between them.
    repeat_draw: assert property (@(posedge clk) disable iff (!rst)
        (draw && $past(draw)) |-> (draw_owner != $past(draw_owner)))
    else begin
        draw_fail = 1'b1;
        $error("two draws in a row for the same player");
    end

    turn_change: assert property (@(posedge clk) disable iff (!rst)
        (whose != $past(whose)) |-> draw)
    else begin
        turn_fail = 1'b1;
        $error("turn changed without a draw");
    end

    count_limit: assert property (@(posedge clk) disable iff (!rst)
        draw_count <= max_cnt)
    else begin
        count_fail = 1'b1;
        $error("draw count above the game limit");
    end

    over_sticky: assert property (@(posedge clk) disable iff (!rst)
        game_over |=> game_over)
    else begin
        over_fail = 1'b1;
        $error("game over fell without a reset");
    end

endmodule

bind card_game_top card_game_asserts #(
    .max_draws (max_draws)
) i_asserts (
    .clk        (clk),
    .rst        (rst),
    .draw       (draw),
    .draw_owner (draw_owner),
    .whose      (whose),
    .draw_count (draw_count),
    .game_over  (game_over)
);

//--- design/card_game_top.sv
module card_game_top
    import card_game_pkg::*;
#(
    parameter int unsigned max_draws = 20
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [3:0]       keypad_in,
    output player_e          whose,
    output color_e           face1_color,
    output color_e           face2_color,
    output logic [num_w-1:0] face1_number,
    output logic [num_w-1:0] face2_number,
    output logic [cnt_w-1:0] draw_count,
    output logic             match,
    output logic             game_over
);

    logic             draw;
    player_e          draw_owner;
    logic [rnd_w-1:0] rnd;

    card_if card_bus ();

    turn_ctrl i_turn_ctrl (
        .clk        (clk),
        .rst        (rst),
        .keypad_in  (keypad_in),
        .game_over  (game_over),
        .draw       (draw),
        .draw_owner (draw_owner),
        .whose      (whose)
    );

    lfsr_draw i_lfsr_draw (
        .clk (clk),
        .rst (rst),
        .rnd (rnd)
    );

    card_decode i_card_decode (
        .clk        (clk),
        .rst        (rst),
        .draw       (draw),
        .draw_owner (draw_owner),
        .rnd        (rnd),
        .card       (card_bus.source)
    );

    table_state #(
        .max_draws (max_draws)
    ) i_table_state (
        .clk          (clk),
        .rst          (rst),
        .card         (card_bus.sink),
        .face1_color  (face1_color),
        .face2_color  (face2_color),
        .face1_number (face1_number),
        .face2_number (face2_number),
        .draw_count   (draw_count),
        .match        (match),
        .game_over    (game_over)
    );

endmodule

//--- design/table_state.sv
module table_state
    import card_game_pkg::*;
#(
    parameter int unsigned max_draws = 20
) (
    input  logic             clk,
    input  logic             rst,
    card_if.sink             card,
    output color_e           face1_color,
    output color_e           face2_color,
    output logic [num_w-1:0] face1_number,
    output logic [num_w-1:0] face2_number,
    output logic [cnt_w-1:0] draw_count,
    output logic             match,
    output logic             game_over
);

    localparam logic [cnt_w-1:0] max_cnt = cnt_w'(max_draws);

    color_e           face1_color_nx;
    color_e           face2_color_nx;
    logic [num_w-1:0] face1_number_nx;
    logic [num_w-1:0] face2_number_nx;
    logic [cnt_w-1:0] draw_count_nx;

    // next table contents, so match and game end see the card being placed.
    always_comb begin
        face1_color_nx  = face1_color;
        face1_number_nx = face1_number;
        face2_color_nx  = face2_color;
        face2_number_nx = face2_number;
        draw_count_nx   = draw_count;
        if (card.valid) begin
            if (card.owner == player1) begin
                face1_color_nx  = card.color;
                face1_number_nx = card.number;
            end else begin
                face2_color_nx  = card.color;
                face2_number_nx = card.number;
            end
            if (draw_count != max_cnt) begin
                draw_count_nx = draw_count + 1'b1; // saturates at max_draws.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            face1_color  <= none;
            face1_number <= '0;
            face2_color  <= none;
            face2_number <= '0;
            draw_count   <= '0;
            match        <= 1'b0;
            game_over    <= 1'b0;
        end else begin
            face1_color  <= face1_color_nx;
            face1_number <= face1_number_nx;
            face2_color  <= face2_color_nx;
            face2_number <= face2_number_nx;
            draw_count   <= draw_count_nx;
            match        <= (face1_color_nx != none) && (face2_color_nx != none) &&
                            (face1_number_nx == face2_number_nx);
            game_over    <= game_over || (draw_count_nx == max_cnt); // sticky till reset.
        end
    end

endmodule

//--- design/card_decode.sv
module card_decode
    import card_game_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             draw,
    input  player_e          draw_owner,
    input  logic [rnd_w-1:0] rnd,
    card_if.source           card
);

    color_e           color_dec;
    logic [num_w-1:0] num_raw;
    logic [num_w-1:0] num_dec;

    always_comb begin
        case (rnd[rnd_w-1:rnd_w-2])
            2'd0:    color_dec = red;
            2'd1:    color_dec = green;
            2'd2:    color_dec = blue;
            default: color_dec = red; // 3 wraps back to red.
        endcase
    end

    // raw value modulo 5, plus 1, gives 1 to 5.
    assign num_raw = rnd[num_w-1:0];
    assign num_dec = (num_raw >= 3'd5) ? num_raw - 3'd4 : num_raw + 3'd1;

    always_ff @(posedge clk) begin
        if (!rst) begin
            card.valid <= 1'b0;
        end else begin
            card.valid <= draw;
        end
    end

    always_ff @(posedge clk) begin
        if (draw) begin
            card.owner  <= draw_owner;
            card.color  <= color_dec;
            card.number <= num_dec;
        end
    end

endmodule

//--- design/lfsr_draw.sv
module lfsr_draw
    import card_game_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    output logic [rnd_w-1:0] rnd
);

    logic feedback;

    // taps at bits 4 and 2 give the full 31-state cycle.
    assign feedback = rnd[4] ^ rnd[2];

    always_ff @(posedge clk) begin
        if (!rst) begin
            rnd <= lfsr_seed;
        end else begin
            rnd <= {rnd[rnd_w-2:0], feedback}; // shift left, feed bit 0.
        end
    end

endmodule

//--- design/turn_ctrl.sv
module turn_ctrl
    import card_game_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [3:0] keypad_in,
    input  logic       game_over,
    output logic       draw,
    output player_e    draw_owner,
    output player_e    whose
);

    turn_state_e state;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= wait_p1;
            draw  <= 1'b0;
        end else begin
            draw <= 1'b0;
            if (!game_over) begin // keys are dead once the game has ended.
                case (state)
                    wait_p1: begin
                        if (keypad_in == key_end_p1) begin
                            state <= wait_p2;
                            draw  <= 1'b1;
                        end
                    end
                    wait_p2: begin
                        if (keypad_in == key_end_p2) begin
                            state <= wait_p1;
                            draw  <= 1'b1;
                        end
                    end
                    default: state <= wait_p1;
                endcase
            end
        end
    end

    // the player whose turn just ended gets the card.
    always_ff @(posedge clk) begin
        if (state == wait_p1) begin
            draw_owner <= player1;
        end else begin
            draw_owner <= player2;
        end
    end

    assign whose = (state == wait_p2) ? player2 : player1; // follows the state at once.

endmodule

//--- design/card_if.sv
interface card_if
    import card_game_pkg::*;
();

    logic             valid;  // one-cycle strobe.
    player_e          owner;
    color_e           color;
    logic [num_w-1:0] number;

    modport source (
        output valid, owner, color, number
    );

    modport sink (
        input valid, owner, color, number
    );

endinterface

//--- design/card_game_pkg.sv
package card_game_pkg;

    // owner of a turn or of a card.
    typedef enum logic {
        player1 = 1'b0,
        player2 = 1'b1
    } player_e;

    typedef enum logic {
        wait_p1 = 1'b0,
        wait_p2 = 1'b1
    } turn_state_e;

    // none marks an empty face slot.
    typedef enum logic [1:0] {
        none  = 2'd0,
        red   = 2'd1,
        green = 2'd2,
        blue  = 2'd3
    } color_e;

    localparam logic [3:0] key_end_p1 = 4'd3; // ends player 1's turn.
    localparam logic [3:0] key_end_p2 = 4'd1; // ends player 2's turn.

    localparam int rnd_w = 5;
    localparam int num_w = 3;
    localparam int cnt_w = 8;

    localparam logic [rnd_w-1:0] lfsr_seed = 5'b10100;

endpackage
